// File: logic/rattlesnake_pkg.sv
// shared widths, RV32I opcode and funct3 constants
// vector typedefs, ALU and sequencer enums, decode and result structs

`default_nettype none

package rattlesnake_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;
    localparam int MEM_ADDR_BITS = 14;
    localparam int NUM_REGS      = 1 << REG_ADDR_BITS;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [XLEN-1:0]          pc_t;
    typedef logic [31:0]              instr_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    // word address, PC bits 15 down to 2
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

    localparam pc_t PC_INC = 32'd4;

    // ------------------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam instr_t WFI_WORD = 32'h1050_0073;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ------------------------------------------------------------------------
    // enums
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, EXECUTE, PAUSED
    } seq_state_e;

    // ------------------------------------------------------------------------
    // stage structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        alu_op_e    alu_op;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        xlen_t      imm;
        pc_t        pc;
        logic       use_imm;
        logic       save_to_rd;
        logic       is_lui;
        logic       is_jal;
        logic       is_branch;
        logic [2:0] br_funct3;
        logic       is_wfi;
        logic       valid;
    } decoded_t;

    typedef struct packed {
        logic      rd_we;
        reg_addr_t rd_addr;
        xlen_t     rd_data;
        logic      redirect;
        pc_t       target;
        logic      done;
    } result_t;

endpackage

`default_nettype wire

// File: logic/fetch_ctrl.sv
// instruction sequencer: IDLE/FETCH/DECODE/EXECUTE/PAUSED
// PC register, code-memory read requests, start and WFI pause handling

`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl import rattlesnake_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,

    input  wire logic     start_i,
    input  wire pc_t      start_address_i,

    input  wire instr_t   mem_read_data_i,
    input  wire logic     mem_read_ack_i,
    output logic          mem_read_en_o,
    output mem_addr_t     mem_addr_o,

    input  wire decoded_t decoded_i,
    input  wire result_t  result_i,

    output logic          fetch_valid_o,
    output instr_t        fetch_ir_o,
    output pc_t           fetch_pc_o,
    output logic          paused_o
);

    seq_state_e state;
    pc_t        pc;
    pc_t        next_pc;

    assign next_pc = result_i.redirect ? result_i.target : pc + PC_INC;

    // ------------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state         <= IDLE;
            pc            <= '0;
            fetch_valid_o <= 1'b0;
            fetch_ir_o    <= '0;
            fetch_pc_o    <= '0;
        end else begin
            fetch_valid_o <= 1'b0;

            case (state)
                IDLE, PAUSED: begin
                    if (start_i) begin
                        pc    <= start_address_i;
                        state <= FETCH;
                    end
                end

                // request held until the memory acks
                FETCH: begin
                    if (mem_read_ack_i) begin
                        fetch_ir_o    <= mem_read_data_i;
                        fetch_pc_o    <= pc;
                        fetch_valid_o <= 1'b1;
                        state         <= DECODE;
                    end
                end

                // wait for the registered decode, WFI parks the core here
                DECODE: begin
                    if (decoded_i.valid) begin
                        state <= decoded_i.is_wfi ? PAUSED : EXECUTE;
                    end
                end

                EXECUTE: begin
                    if (result_i.done) begin
                        pc    <= next_pc;
                        state <= FETCH;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------
    assign mem_read_en_o = (state == FETCH);
    assign mem_addr_o    = pc[MEM_ADDR_BITS+1:2];
    assign paused_o      = (state == IDLE) || (state == PAUSED);

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
// instruction decoder for the kept RV32I subset
// immediate formats, ALU op select, registered decode struct

`timescale 1ns/100ps
`default_nettype none

module instr_decode import rattlesnake_pkg::*; (
    input  wire logic   clk,
    input  wire logic   arst_n_i,

    input  wire logic   fetch_valid_i,
    input  wire instr_t fetch_ir_i,
    input  wire pc_t    fetch_pc_i,

    output decoded_t    decoded_o,
    output reg_addr_t   rs1_addr_o,
    output reg_addr_t   rs2_addr_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      imm_b;
    alu_op_e    alu_op;
    decoded_t   dec_d;
    decoded_t   dec_q;

    assign opcode    = fetch_ir_i[6:0];
    assign funct3    = fetch_ir_i[14:12];
    assign funct7_b5 = fetch_ir_i[30];

    // ------------------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------------------
    assign imm_i = {{20{fetch_ir_i[31]}}, fetch_ir_i[31:20]};
    assign imm_u = {fetch_ir_i[31:12], 12'b0};
    assign imm_j = {{12{fetch_ir_i[31]}}, fetch_ir_i[19:12], fetch_ir_i[20],
                    fetch_ir_i[30:21], 1'b0};
    assign imm_b = {{20{fetch_ir_i[31]}}, fetch_ir_i[7], fetch_ir_i[30:25],
                    fetch_ir_i[11:8], 1'b0};

    // SUB only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    // ------------------------------------------------------------------------
    // opcode class
    // ------------------------------------------------------------------------
    always_comb begin
        dec_d           = '0;
        dec_d.alu_op    = alu_op;
        dec_d.rd        = fetch_ir_i[11:7];
        dec_d.rs1       = fetch_ir_i[19:15];
        dec_d.rs2       = fetch_ir_i[24:20];
        dec_d.pc        = fetch_pc_i;
        dec_d.br_funct3 = funct3;
        dec_d.valid     = fetch_valid_i;

        // anything else falls through as a no-op
        case (opcode)
            OPC_OP: begin
                dec_d.save_to_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_d.save_to_rd = 1'b1;
                dec_d.use_imm    = 1'b1;
                dec_d.imm        = imm_i;
            end
            OPC_LUI: begin
                dec_d.save_to_rd = 1'b1;
                dec_d.is_lui     = 1'b1;
                dec_d.imm        = imm_u;
            end
            OPC_JAL: begin
                dec_d.save_to_rd = 1'b1;
                dec_d.is_jal     = 1'b1;
                dec_d.imm        = imm_j;
            end
            OPC_BRANCH: begin
                dec_d.is_branch = 1'b1;
                dec_d.imm       = imm_b;
            end
            OPC_SYSTEM: begin
                dec_d.is_wfi = (fetch_ir_i == WFI_WORD);
            end
            default: begin
                dec_d.save_to_rd = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_q <= '0;
        end else if (fetch_valid_i) begin
            dec_q <= dec_d;
        end else begin
            dec_q.valid <= 1'b0;
        end
    end

    assign decoded_o  = dec_q;
    assign rs1_addr_o = dec_q.rs1;
    assign rs2_addr_o = dec_q.rs2;

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
// execute stage: ALU, LUI value, branch compare
// branch and jump targets, JAL link, registered result struct

`timescale 1ns/100ps
`default_nettype none

module exec_unit import rattlesnake_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,

    input  wire decoded_t decoded_i,
    input  wire xlen_t    rs1_data_i,
    input  wire xlen_t    rs2_data_i,

    output result_t       result_o
);

    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;
    xlen_t      alu_res;
    logic       br_taken;
    pc_t        link;
    result_t    res_d;

    assign op_a  = rs1_data_i;
    assign op_b  = decoded_i.use_imm ? decoded_i.imm : rs2_data_i;
    assign shamt = op_b[4:0];
    assign link  = decoded_i.pc + PC_INC;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (decoded_i.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_res = xlen_t'(op_a < op_b);
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            default:  alu_res = op_a & op_b;
        endcase
    end

    // branch compare is always register to register
    always_comb begin
        case (decoded_i.br_funct3)
            F3_BEQ:  br_taken = (rs1_data_i == rs2_data_i);
            F3_BNE:  br_taken = (rs1_data_i != rs2_data_i);
            F3_BLT:  br_taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            F3_BGE:  br_taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            F3_BLTU: br_taken = (rs1_data_i < rs2_data_i);
            F3_BGEU: br_taken = (rs1_data_i >= rs2_data_i);
            default: br_taken = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // result
    // ------------------------------------------------------------------------
    always_comb begin
        res_d          = '0;
        res_d.rd_addr  = decoded_i.rd;
        res_d.rd_we    = decoded_i.valid && decoded_i.save_to_rd;
        res_d.done     = decoded_i.valid && !decoded_i.is_wfi;
        // JAL and branch share the pc-relative target
        res_d.target   = decoded_i.pc + decoded_i.imm;
        res_d.redirect = decoded_i.is_jal || (decoded_i.is_branch && br_taken);

        if (decoded_i.is_lui) begin
            res_d.rd_data = decoded_i.imm;
        end else if (decoded_i.is_jal) begin
            res_d.rd_data = link;
        end else begin
            res_d.rd_data = alu_res;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else if (decoded_i.valid) begin
            result_o <= res_d;
        end else begin
            result_o.done     <= 1'b0;
            result_o.rd_we    <= 1'b0;
            result_o.redirect <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
// 32 x 32 architectural register file
// writeback from the result struct, debug read shared with port 2

`timescale 1ns/100ps
`default_nettype none

module reg_file import rattlesnake_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst_n_i,

    input  wire result_t   result_i,

    input  wire reg_addr_t rs1_addr_i,
    input  wire reg_addr_t rs2_addr_i,
    input  wire reg_addr_t dbg_addr_i,
    input  wire logic      paused_i,

    output xlen_t          rs1_data_o,
    output xlen_t          rs2_data_o,
    output xlen_t          dbg_data_o
);

    xlen_t     regs [NUM_REGS];
    reg_addr_t port2_addr;
    xlen_t     port2_data;

    // x0 is never written so it keeps its reset zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (result_i.rd_we && (result_i.rd_addr != '0)) begin
            regs[result_i.rd_addr] <= result_i.rd_data;
        end
    end

    // debugger borrows port 2 while the core is paused
    assign port2_addr = paused_i ? dbg_addr_i : rs2_addr_i;
    assign port2_data = regs[port2_addr];

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = port2_data;
    assign dbg_data_o = port2_data;

endmodule

`default_nettype wire

// File: logic/rattlesnake_core.sv
// core top level
// fetch control, decode, execute and register file wired together

`timescale 1ns/100ps
`default_nettype none

module rattlesnake_core import rattlesnake_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst_n_i,

    input  wire logic      start_i,
    input  wire pc_t       start_address_i,

    input  wire instr_t    mem_read_data_i,
    input  wire logic      mem_read_ack_i,
    output logic           mem_read_en_o,
    output mem_addr_t      mem_addr_o,

    output logic           processor_paused_o,
    output pc_t            peek_pc_o,
    output instr_t         peek_ir_o,

    input  wire reg_addr_t dbg_reg_addr_i,
    output xlen_t          dbg_reg_data_o
);

    logic      fetch_valid;
    instr_t    fetch_ir;
    pc_t       fetch_pc;
    logic      paused;
    decoded_t  decoded;
    result_t   result;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    fetch_ctrl u_fetch_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .start_i         (start_i),
        .start_address_i (start_address_i),
        .mem_read_data_i (mem_read_data_i),
        .mem_read_ack_i  (mem_read_ack_i),
        .mem_read_en_o   (mem_read_en_o),
        .mem_addr_o      (mem_addr_o),
        .decoded_i       (decoded),
        .result_i        (result),
        .fetch_valid_o   (fetch_valid),
        .fetch_ir_o      (fetch_ir),
        .fetch_pc_o      (fetch_pc),
        .paused_o        (paused)
    );

    instr_decode u_instr_decode (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .fetch_valid_i (fetch_valid),
        .fetch_ir_i    (fetch_ir),
        .fetch_pc_i    (fetch_pc),
        .decoded_o     (decoded),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr)
    );

    exec_unit u_exec_unit (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .decoded_i  (decoded),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (result)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .result_i   (result),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .dbg_addr_i (dbg_reg_addr_i),
        .paused_i   (paused),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_data_o (dbg_reg_data_o)
    );

    // peek shows the instruction last fetched
    assign peek_pc_o          = fetch_pc;
    assign peek_ir_o          = fetch_ir;
    assign processor_paused_o = paused;

endmodule

`default_nettype wire

// File: dv/rattlesnake_core_sva.sv
// code-memory request protocol and pause checks
// bound into the core top level

`timescale 1ns/100ps
`default_nettype none

module rattlesnake_core_sva import rattlesnake_pkg::*; (
    input wire logic      clk,
    input wire logic      arst_n_i,
    input wire logic      start_i,
    input wire logic      mem_read_en_o,
    input wire mem_addr_t mem_addr_o,
    input wire logic      mem_read_ack_i,
    input wire logic      processor_paused_o
);

    // request stays up with a steady address until acked
    assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_read_en_o && !mem_read_ack_i |=> mem_read_en_o && $stable(mem_addr_o))
        else $error("read request dropped or address moved before ack");

    // request falls the cycle after ack
    assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_read_ack_i |=> !mem_read_en_o)
        else $error("read request still high after ack");

    // a paused core stays paused and quiet until started
    assert property (@(posedge clk) disable iff (!arst_n_i)
        processor_paused_o && !start_i |=> processor_paused_o && !mem_read_en_o)
        else $error("code read issued or pause left without a start pulse");

    // quiet bus through reset and the first cycle out of it
    assert property (@(posedge clk) !arst_n_i |=> !mem_read_en_o)
        else $error("code read issued during or right after reset");

endmodule

bind rattlesnake_core rattlesnake_core_sva u_core_sva (
    .clk                (clk),
    .arst_n_i           (arst_n_i),
    .start_i            (start_i),
    .mem_read_en_o      (mem_read_en_o),
    .mem_addr_o         (mem_addr_o),
    .mem_read_ack_i     (mem_read_ack_i),
    .processor_paused_o (processor_paused_o)
);

`default_nettype wire

// File: dv/rattlesnake_core_tb.sv
// directed tests for the core: reset, ALU, LUI, branches and JAL, restart
// code-memory model with variable ack latency, instruction-level reference model

`timescale 1ns/100ps
`default_nettype none

module rattlesnake_core_tb import rattlesnake_pkg::*; ();

    localparam int  HALF_PERIOD  = 20;
    localparam int  CODE_WORDS   = 1 << MEM_ADDR_BITS;
    localparam int  RUN_TIMEOUT  = 5000;
    localparam int  MODEL_STEPS  = 1000;
    localparam pc_t ALU_BASE     = 32'h0000_0100;
    localparam pc_t LUI_BASE     = 32'h0000_0400;
    localparam pc_t BR_BASE      = 32'h0000_0800;
    localparam pc_t RESTART_BASE = 32'h0000_2000;

    logic      clk = 1'b0;
    logic      arst_n_i;
    logic      start_i;
    pc_t       start_address_i;
    instr_t    mem_read_data_i;
    logic      mem_read_ack_i;
    logic      mem_read_en_o;
    mem_addr_t mem_addr_o;
    logic      processor_paused_o;
    pc_t       peek_pc_o;
    instr_t    peek_ir_o;
    reg_addr_t dbg_reg_addr_i;
    xlen_t     dbg_reg_data_o;

    instr_t    code_mem [CODE_WORDS];
    xlen_t     exp_regs [NUM_REGS];
    mem_addr_t load_ptr;
    logic      random_latency = 1'b0;
    int        ack_wait;
    int        mismatch_count = 0;
    int        timeout_count  = 0;

    rattlesnake_core dut_i (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .start_i            (start_i),
        .start_address_i    (start_address_i),
        .mem_read_data_i    (mem_read_data_i),
        .mem_read_ack_i     (mem_read_ack_i),
        .mem_read_en_o      (mem_read_en_o),
        .mem_addr_o         (mem_addr_o),
        .processor_paused_o (processor_paused_o),
        .peek_pc_o          (peek_pc_o),
        .peek_ir_o          (peek_ir_o),
        .dbg_reg_addr_i     (dbg_reg_addr_i),
        .dbg_reg_data_o     (dbg_reg_data_o)
    );

    // 40 ns period
    always #HALF_PERIOD clk = ~clk;

    // ------------------------------------------------------------------------
    // code memory, one ack pulse per request after 1 to 4 cycles
    // ------------------------------------------------------------------------
    initial begin : code_mem_model
        void'($urandom(55));
        mem_read_ack_i  = 1'b0;
        mem_read_data_i = '0;
        ack_wait        = -1;
        forever begin
            @(posedge clk);
            #2;
            if (mem_read_ack_i) begin
                mem_read_ack_i = 1'b0;
            end else if (mem_read_en_o) begin
                if (ack_wait < 0) begin
                    ack_wait = random_latency ? int'($urandom_range(3, 0)) : 0;
                end
                if (ack_wait == 0) begin
                    mem_read_data_i = code_mem[mem_addr_o];
                    mem_read_ack_i  = 1'b1;
                end
                ack_wait--;
            end
        end
    end

    // ------------------------------------------------------------------------
    // program building
    // ------------------------------------------------------------------------
    task automatic put_word(input instr_t w);
        code_mem[load_ptr] = w;
        load_ptr++;
    endtask

    task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                           input int rs1, input int rs2);
        put_word({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP});
    endtask

    task automatic alu_imm(input logic [2:0] f3, input int rd, input int rs1, input int imm);
        put_word({imm[11:0], rs1[4:0], f3, rd[4:0], OPC_OP_IMM});
    endtask

    task automatic load_upper(input int rd, input int imm20);
        put_word({imm20[19:0], rd[4:0], OPC_LUI});
    endtask

    task automatic jump_link(input int rd, input int off);
        put_word({off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL});
    endtask

    task automatic branch_to(input logic [2:0] f3, input int rs1, input int rs2, input int off);
        put_word({off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH});
    endtask

    // branch over an ori that marks one bit of x22
    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2, input int b);
        branch_to(f3, rs1, rs2, 8);
        alu_imm(3'b110, 22, 22, 1 << b);
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic write_reg(input reg_addr_t rd, input xlen_t v);
        if (rd != '0) begin
            exp_regs[rd] = v;
        end
    endtask

    task automatic run_model(input pc_t start_pc, output pc_t wfi_pc);
        pc_t    pc;
        pc_t    next_pc;
        instr_t ir;
        xlen_t  a;
        xlen_t  b;
        int     steps;
        pc    = start_pc;
        ir    = code_mem[pc[15:2]];
        steps = 0;
        while (ir != WFI_WORD && steps < MODEL_STEPS) begin
            a       = exp_regs[ir[19:15]];
            b       = exp_regs[ir[24:20]];
            next_pc = pc + 32'd4;
            case (ir[6:0])
                OPC_OP:     write_reg(ir[11:7], alu_ref(ir[14:12], ir[30], a, b));
                OPC_OP_IMM: write_reg(ir[11:7], alu_ref(ir[14:12],
                                ir[30] && (ir[14:12] == 3'b101), a, {{20{ir[31]}}, ir[31:20]}));
                OPC_LUI:    write_reg(ir[11:7], {ir[31:12], 12'b0});
                OPC_JAL: begin
                    write_reg(ir[11:7], pc + 32'd4);
                    next_pc = pc + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
                end
                OPC_BRANCH: begin
                    if (branch_ref(ir[14:12], a, b)) begin
                        next_pc = pc + {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            pc = next_pc;
            ir = code_mem[pc[15:2]];
            steps++;
        end
        wfi_pc = pc;
    endtask

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %08h, actual %08h", what, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_pc(input string what, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected pc %08h, actual pc %08h", what, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_instr(input string what, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected ir %08h, actual ir %08h", what, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic expect_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", what, exp, act);
            mismatch_count++;
        end
    endtask

    // debug port, one register per cycle
    task automatic read_all_regs(input string name);
        for (int i = 0; i < NUM_REGS; i++) begin
            dbg_reg_addr_i = reg_addr_t'(i);
            #10;
            check_xlen($sformatf("%s x%0d", name, i), exp_regs[dbg_reg_addr_i], dbg_reg_data_o);
            @(posedge clk);
            #2;
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        for (int i = 0; i < 8; i++) begin
            expect_flag("reset paused", 1'b1, processor_paused_o);
            expect_flag("reset mem_read_en", 1'b0, mem_read_en_o);
            @(posedge clk);
            #2;
        end
        read_all_regs("reset");
    endtask

    task automatic run_program(input string name, input pc_t start_pc);
        pc_t wfi_pc;
        int  cycles;
        run_model(start_pc, wfi_pc);
        start_address_i = start_pc;
        start_i         = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        cycles  = 0;
        while (!processor_paused_o && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!processor_paused_o) begin
            $display("ERROR %s: core did not pause within %0d cycles", name, RUN_TIMEOUT);
            timeout_count++;
        end else begin
            check_pc({name, " peek_pc"}, wfi_pc, peek_pc_o);
            check_instr({name, " peek_ir"}, WFI_WORD, peek_ir_o);
            read_all_regs(name);
        end
    endtask

    task automatic load_programs();
        // ALU, register and immediate forms
        load_ptr = ALU_BASE[15:2];
        alu_imm(3'b000, 1, 0, 100);
        alu_imm(3'b000, 2, 0, -7);
        alu_reg(7'h00, 3'b000, 3, 1, 2);
        alu_reg(7'h20, 3'b000, 4, 2, 1);
        alu_imm(3'b001, 5, 2, 3);
        alu_imm(3'b101, 6, 2, 4);
        alu_imm(3'b101, 7, 2, 12'h402);
        alu_reg(7'h00, 3'b010, 8, 2, 1);
        alu_reg(7'h00, 3'b011, 9, 2, 1);
        alu_imm(3'b100, 10, 1, -1);
        alu_reg(7'h00, 3'b110, 11, 1, 2);
        alu_reg(7'h00, 3'b111, 12, 1, 2);
        alu_reg(7'h00, 3'b001, 13, 1, 2);
        alu_reg(7'h20, 3'b101, 14, 2, 1);
        alu_imm(3'b010, 15, 2, -1);
        alu_imm(3'b011, 16, 1, -1);
        alu_imm(3'b111, 17, 2, 12'h0f0);
        alu_imm(3'b110, 18, 1, -2048);
        put_word(WFI_WORD);
        // LUI and x0 writes
        load_ptr = LUI_BASE[15:2];
        load_upper(19, 20'hABCDE);
        load_upper(20, 20'h80000);
        alu_imm(3'b000, 20, 20, 12'h123);
        load_upper(0, 20'h12345);
        alu_imm(3'b000, 0, 1, 55);
        alu_reg(7'h00, 3'b000, 21, 0, 19);
        put_word(WFI_WORD);
        // one taken and one not-taken case per branch kind, then JAL and a loop
        load_ptr = BR_BASE[15:2];
        branch_case(F3_BEQ, 1, 1, 0);
        branch_case(F3_BEQ, 1, 2, 1);
        branch_case(F3_BNE, 1, 2, 2);
        branch_case(F3_BNE, 1, 1, 3);
        branch_case(F3_BLT, 2, 1, 4);
        branch_case(F3_BLT, 1, 2, 5);
        branch_case(F3_BGE, 1, 2, 6);
        branch_case(F3_BGE, 2, 1, 7);
        branch_case(F3_BLTU, 1, 2, 8);
        branch_case(F3_BLTU, 2, 1, 9);
        branch_case(F3_BGEU, 2, 1, 10);
        branch_case(F3_BGEU, 1, 2, 11);
        jump_link(24, 12);
        alu_imm(3'b000, 25, 0, 1);
        alu_imm(3'b000, 25, 0, 2);
        alu_imm(3'b000, 26, 0, 3);
        alu_imm(3'b000, 26, 26, -1);
        alu_imm(3'b000, 27, 27, 5);
        branch_to(F3_BNE, 26, 0, -8);
        put_word(WFI_WORD);
        // second run, reads registers left by the first
        load_ptr = RESTART_BASE[15:2];
        alu_reg(7'h00, 3'b000, 28, 3, 19);
        alu_reg(7'h20, 3'b000, 29, 22, 27);
        jump_link(30, 8);
        alu_imm(3'b000, 31, 0, -1);
        alu_imm(3'b000, 31, 30, 4);
        put_word(WFI_WORD);
    endtask

    initial begin
        arst_n_i        = 1'b0;
        start_i         = 1'b0;
        start_address_i = '0;
        dbg_reg_addr_i  = '0;
        exp_regs        = '{default: '0};
        // unused words decode as a no-op carrying their own address
        for (int a = 0; a < CODE_WORDS; a++) begin
            code_mem[mem_addr_t'(a)] = {4'b0, a[13:0], 7'b0, 7'b0001111};
        end
        load_programs();

        repeat (16) @(posedge clk);
        #2;
        arst_n_i = 1'b1;

        test_reset();
        run_program("alu", ALU_BASE);
        run_program("lui", LUI_BASE);
        run_program("branch", BR_BASE);
        run_program("restart", RESTART_BASE);
        random_latency = 1'b1;
        run_program("random alu", ALU_BASE);
        run_program("random branch", BR_BASE);

        $display("summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/rattlesnake_pkg.sv
logic/fetch_ctrl.sv
logic/instr_decode.sv
logic/exec_unit.sv
logic/reg_file.sv
logic/rattlesnake_core.sv
dv/rattlesnake_core_sva.sv
dv/rattlesnake_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rattlesnake_core_tb
FILELIST  = sim.f

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
